//--- Makefile
# Verilator build and run for the tile endpoint testbench

VERILATOR ?= verilator
TOP       ?= mc_endpoint_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= >>> PASS

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
src/mc_pkg.sv
src/mc_op_if.sv
src/mc_reset_seq.sv
src/mc_packet_decode.sv
src/mc_dmem_execute.sv
src/mc_response.sv
src/mc_endpoint_top.sv
verification/mc_endpoint_assertions.sv
verification/mc_endpoint_tb.sv

//--- src/mc_dmem_execute.sv
// ----------------------------------------------------------------------
// execute stage with the local data memory
// store, load and atomic add against a word-addressed array
// asynchronous read, write at the clock edge
// control slots pass through unchanged
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module mc_dmem_execute #(
  parameter int dmem_words_p = 1024
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  mc_op_if.dst  op_i,
  mc_op_if.src  res_o
);
  import mc_pkg::*;

  localparam int idx_w_lp = (dmem_words_p > 1) ? $clog2(dmem_words_p) : 1;

  mc_data_t            mem [dmem_words_p];
  logic [idx_w_lp-1:0] idx;
  mc_data_t            rd_data;
  mc_data_t            wr_data;
  logic                wr_en;
  mc_data_t            res_data;

  assign idx     = op_i.addr[idx_w_lp-1:0];
  assign rd_data = mem[idx];   // sees last cycle's write

  always_comb begin
    wr_en    = 1'b0;
    wr_data  = op_i.data;
    res_data = op_i.data;
    unique case (op_i.op)
      MC_OP_STORE: begin
        wr_en = op_i.v;
      end
      MC_OP_LOAD: begin
        res_data = rd_data;
      end
      MC_OP_AMOADD: begin
        wr_en    = op_i.v;
        wr_data  = rd_data + op_i.data;
        res_data = rd_data;   // old value back to the host
      end
      default: ;              // control untouched
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) mem[idx] <= wr_data;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_o.v <= 1'b0;
    end else begin
      res_o.v <= op_i.v;
    end
  end

  always_ff @(posedge clk_i) begin
    if (op_i.v) begin
      res_o.op   <= op_i.op;
      res_o.addr <= op_i.addr;
      res_o.data <= res_data;
    end
  end

endmodule

//--- src/mc_endpoint_top.sv
// ----------------------------------------------------------------------
// tile endpoint top level
// reset sequencer plus decode, execute and result stages
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module mc_endpoint_top #(
  parameter int dmem_words_p  = 1024,
  parameter int init_cycles_p = 16,
  parameter int reset_depth_p = 3
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               pkt_v_i,
  input  mc_pkg::mc_opcode_t pkt_op_i,
  input  mc_pkg::mc_addr_t   pkt_addr_i,
  input  mc_pkg::mc_data_t   pkt_data_i,
  output logic               ready_o,
  output logic               resp_v_o,
  output mc_pkg::mc_opcode_t resp_op_o,
  output mc_pkg::mc_data_t   resp_data_o,
  output logic               stat_v_o,
  output mc_pkg::mc_data_t   stat_tag_o,
  output mc_pkg::mc_cycle_t  stat_cycle_o,
  output logic               finish_o
);

  logic core_ready;

  mc_op_if dec2ex ();
  mc_op_if ex2res ();

  mc_reset_seq #(
    .init_cycles_p(init_cycles_p)
    ,.reset_depth_p(reset_depth_p)
  ) reset_seq (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.core_ready_o(core_ready)
  );

  assign ready_o = core_ready;

  mc_packet_decode decode (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.core_ready_i(core_ready)
    ,.pkt_v_i(pkt_v_i)
    ,.pkt_op_i(pkt_op_i)
    ,.pkt_addr_i(pkt_addr_i)
    ,.pkt_data_i(pkt_data_i)
    ,.op_o(dec2ex.src)
  );

  mc_dmem_execute #(
    .dmem_words_p(dmem_words_p)
  ) execute (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.op_i(dec2ex.dst)
    ,.res_o(ex2res.src)
  );

  mc_response result (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.core_ready_i(core_ready)
    ,.res_i(ex2res.dst)
    ,.resp_v_o(resp_v_o)
    ,.resp_op_o(resp_op_o)
    ,.resp_data_o(resp_data_o)
    ,.stat_v_o(stat_v_o)
    ,.stat_tag_o(stat_tag_o)
    ,.stat_cycle_o(stat_cycle_o)
    ,.finish_o(finish_o)
  );

endmodule

//--- src/mc_op_if.sv
// ----------------------------------------------------------------------
// one operation slot passed between pipeline stages
// src modport drives the slot, dst modport receives it
// ----------------------------------------------------------------------

`timescale 1ns/100ps

interface mc_op_if;
  import mc_pkg::*;

  logic       v;
  mc_opcode_t op;
  mc_addr_t   addr;
  mc_data_t   data;   // operand, or result after execute

  modport src (
    output v,
    output op,
    output addr,
    output data
  );

  modport dst (
    input v,
    input op,
    input addr,
    input data
  );

endinterface

//--- src/mc_packet_decode.sv
// ----------------------------------------------------------------------
// packet decode stage
// samples host packets once the core is released
// control packets with an unknown address become empty slots
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module mc_packet_decode (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               core_ready_i,
  input  logic               pkt_v_i,
  input  mc_pkg::mc_opcode_t pkt_op_i,
  input  mc_pkg::mc_addr_t   pkt_addr_i,
  input  mc_pkg::mc_data_t   pkt_data_i,
  mc_op_if.src               op_o
);
  import mc_pkg::*;

  logic is_ctrl;
  logic ctrl_known;
  logic accept;

  assign is_ctrl    = (pkt_op_i == MC_OP_CTRL);
  assign ctrl_known = (pkt_addr_i == MC_CTRL_PRINT_STAT)
                   || (pkt_addr_i == MC_CTRL_FINISH);

  // drop everything before release
  assign accept = pkt_v_i && core_ready_i && (!is_ctrl || ctrl_known);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      op_o.v <= 1'b0;
    end else begin
      op_o.v <= accept;
    end
  end

  // slot fields qualified by v
  always_ff @(posedge clk_i) begin
    if (pkt_v_i) begin
      op_o.op   <= pkt_op_i;
      op_o.addr <= pkt_addr_i;
      op_o.data <= pkt_data_i;
    end
  end

endmodule

//--- src/mc_pkg.sv
// ----------------------------------------------------------------------
// shared definitions for the tile endpoint
// data, address, opcode and cycle widths
// opcode values and control-packet addresses
// reset sequencer state encoding
// ----------------------------------------------------------------------

package mc_pkg;

  // payload widths
  typedef logic [31:0] mc_data_t;
  typedef logic [9:0]  mc_addr_t;   // word address
  typedef logic [1:0]  mc_opcode_t;
  typedef logic [31:0] mc_cycle_t;

  // packet opcodes
  localparam mc_opcode_t MC_OP_STORE  = 2'd0;
  localparam mc_opcode_t MC_OP_LOAD   = 2'd1;
  localparam mc_opcode_t MC_OP_AMOADD = 2'd2;  // returns old value
  localparam mc_opcode_t MC_OP_CTRL   = 2'd3;

  // control ops are selected by the packet address
  localparam mc_addr_t MC_CTRL_PRINT_STAT = 10'd0;
  localparam mc_addr_t MC_CTRL_FINISH     = 10'd1;

  // reset sequencer
  typedef enum logic [1:0] {
    SEQ_INIT,   // tag programming
    SEQ_CHAIN,  // done bit moving through the reset flops
    SEQ_RUN
  } mc_seq_state_e;

endpackage

//--- src/mc_reset_seq.sv
// ----------------------------------------------------------------------
// reset sequencer for the endpoint core
// counts out the tag-programming phase, then releases the core
// through a chain of reset_depth_p flops
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module mc_reset_seq #(
  parameter int init_cycles_p = 16,
  parameter int reset_depth_p = 3
) (
  input  logic clk_i,
  input  logic rst_n_i,
  output logic core_ready_o
);
  import mc_pkg::*;

  localparam int cnt_w_lp = (init_cycles_p > 1) ? $clog2(init_cycles_p) : 1;

  mc_seq_state_e          state_r;
  logic [cnt_w_lp-1:0]    cnt_r;
  logic [reset_depth_p-1:0] chain_r;
  logic                   tag_done;

  assign tag_done = (state_r != SEQ_INIT);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= SEQ_INIT;
      cnt_r   <= '0;
    end else begin
      unique case (state_r)
        SEQ_INIT: begin
          cnt_r <= cnt_r + 1'b1;
          if (cnt_r == cnt_w_lp'(init_cycles_p - 1)) state_r <= SEQ_CHAIN;
        end
        SEQ_CHAIN: if (core_ready_o) state_r <= SEQ_RUN;
        SEQ_RUN:   state_r <= SEQ_RUN;   // held until reset
        default:   state_r <= SEQ_INIT;
      endcase
    end
  end

  // done bit shifts toward the release output
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      chain_r <= '0;
    end else begin
      chain_r <= (chain_r << 1) | reset_depth_p'(tag_done);
    end
  end

  assign core_ready_o = chain_r[reset_depth_p-1];

endmodule

//--- src/mc_response.sv
// ----------------------------------------------------------------------
// result stage
// cycle counter started by core release
// response pulses for load and atomic add
// print-stat strobe and sticky finish level
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module mc_response (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               core_ready_i,
  mc_op_if.dst               res_i,
  output logic               resp_v_o,
  output mc_pkg::mc_opcode_t resp_op_o,
  output mc_pkg::mc_data_t   resp_data_o,
  output logic               stat_v_o,
  output mc_pkg::mc_data_t   stat_tag_o,
  output mc_pkg::mc_cycle_t  stat_cycle_o,
  output logic               finish_o
);
  import mc_pkg::*;

  mc_cycle_t cycle_r;
  logic      resp_hit;
  logic      stat_hit;
  logic      finish_hit;

  assign resp_hit   = res_i.v && ((res_i.op == MC_OP_LOAD) || (res_i.op == MC_OP_AMOADD));
  assign stat_hit   = res_i.v && (res_i.op == MC_OP_CTRL)
                   && (res_i.addr == MC_CTRL_PRINT_STAT);
  assign finish_hit = res_i.v && (res_i.op == MC_OP_CTRL)
                   && (res_i.addr == MC_CTRL_FINISH);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cycle_r  <= '0;
      resp_v_o <= 1'b0;
      stat_v_o <= 1'b0;
      finish_o <= 1'b0;
    end else begin
      if (core_ready_i) cycle_r <= cycle_r + 1'b1;
      resp_v_o <= resp_hit;
      stat_v_o <= stat_hit;
      if (finish_hit) finish_o <= 1'b1;   // sticky
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp_hit) begin
      resp_op_o   <= res_i.op;
      resp_data_o <= res_i.data;
    end
    if (stat_hit) begin
      stat_tag_o   <= res_i.data;
      stat_cycle_o <= cycle_r;
    end
  end

endmodule

//--- verification/mc_endpoint_assertions.sv
// ----------------------------------------------------------------------
// concurrent checks on the endpoint top-level ports
// no strobes before release, sticky ready and finish
// legal opcode on every response
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module mc_endpoint_assertions (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               ready_i,
  input logic               resp_v_i,
  input mc_pkg::mc_opcode_t resp_op_i,
  input logic               stat_v_i,
  input logic               finish_i
);
  import mc_pkg::*;

  quiet_before_ready: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !ready_i |-> !resp_v_i && !stat_v_i
  ) else $error("response or stat strobe while the core is held");

  ready_sticky: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) ready_i |=> ready_i
  ) else $error("ready dropped without reset");

  finish_sticky: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) finish_i |=> finish_i
  ) else $error("finish dropped without reset");

  // stores and control never answer on the response port
  resp_op_legal: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      resp_v_i |-> (resp_op_i == MC_OP_LOAD) || (resp_op_i == MC_OP_AMOADD)
  ) else $error("response carries an opcode other than load or atomic add");

endmodule

bind mc_endpoint_top mc_endpoint_assertions asrt0 (
  .clk_i(clk_i),
  .rst_n_i(rst_n_i),
  .ready_i(ready_o),
  .resp_v_i(resp_v_o),
  .resp_op_i(resp_op_o),
  .stat_v_i(stat_v_o),
  .finish_i(finish_o)
);

//--- verification/mc_endpoint_tb.sv
// ----------------------------------------------------------------------
// testbench for the tile endpoint
// clock and reset, xorshift stimulus, reference memory model
// expectation queues compared at the fixed pipeline latency
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module mc_endpoint_tb;
  import mc_pkg::*;

  localparam int init_cycles_lp = 16;
  localparam int reset_depth_lp = 3;
  localparam int latency_lp     = 4;   // drive edge to sample edge
  localparam int never_lp       = 32'h7fff_ffff;

  typedef enum {KIND_NONE, KIND_RESP, KIND_STAT, KIND_FINISH} kind_e;

  typedef struct packed {
    int         due;
    mc_opcode_t op;
    mc_data_t   data;
  } resp_exp_t;

  typedef struct packed {
    int       due;
    int       issue;
    mc_data_t tag;
  } stat_exp_t;

  logic       clk_i;
  logic       rst_n_i;
  logic       pkt_v_i;
  mc_opcode_t pkt_op_i;
  mc_addr_t   pkt_addr_i;
  mc_data_t   pkt_data_i;
  logic       ready_o;
  logic       resp_v_o;
  mc_opcode_t resp_op_o;
  mc_data_t   resp_data_o;
  logic       stat_v_o;
  mc_data_t   stat_tag_o;
  mc_cycle_t  stat_cycle_o;
  logic       finish_o;

  int          stamp;                    // edges seen so far
  int          ready_stamp = never_lp;
  int          finish_due  = never_lp;
  int          last_due    = 0;
  bit          released    = 1'b0;
  logic [31:0] rng_state   = 32'h09b3_3bdc;
  mc_data_t    ref_mem [1024];
  bit          written [1024];
  mc_addr_t    written_q [$];
  resp_exp_t   resp_q [$];
  stat_exp_t   stat_q [$];

  mc_endpoint_top #(
    .init_cycles_p(init_cycles_lp),
    .reset_depth_p(reset_depth_lp)
  ) dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    stamp = 0;
    forever @(posedge clk_i) stamp <= stamp + 1;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // loads and atomic adds only touch written words since dmem holds no reset value
  function automatic mc_addr_t pick_written();
    int idx;
    idx = int'(next_rand() % 32'(written_q.size()));
    return written_q[idx];
  endfunction

  // expected result and output kind of one accepted packet
  function automatic mc_data_t ref_model(input mc_opcode_t op, input mc_addr_t addr,
                                         input mc_data_t data, output kind_e kind);
    mc_data_t old;
    mc_data_t result;
    old    = ref_mem[addr];
    result = data;
    kind   = KIND_NONE;
    case (op)
      MC_OP_STORE: ref_mem[addr] = data;
      MC_OP_LOAD: begin
        kind   = KIND_RESP;
        result = old;
      end
      MC_OP_AMOADD: begin
        kind          = KIND_RESP;
        ref_mem[addr] = old + data;   // wraps mod 2^32
        result        = old;
      end
      default: begin
        if (addr == MC_CTRL_PRINT_STAT) kind = KIND_STAT;
        else if (addr == MC_CTRL_FINISH) kind = KIND_FINISH;
      end
    endcase
    return result;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_resp(input mc_opcode_t exp_op, input mc_data_t exp_data,
                            input mc_opcode_t got_op, input mc_data_t got_data);
    if (got_op !== exp_op || got_data !== exp_data)
      fail_now($sformatf("mismatch at %0t: response expected op %0d data %h, got op %0d data %h",
                         $time, exp_op, exp_data, got_op, got_data));
  endtask

  task automatic check_stat(input mc_data_t exp_tag, input mc_cycle_t min_cycle,
                            input mc_data_t got_tag, input mc_cycle_t got_cycle);
    if (got_tag !== exp_tag)
      fail_now($sformatf("mismatch at %0t: stat tag expected %h, got %h",
                         $time, exp_tag, got_tag));
    if (got_cycle < min_cycle)
      fail_now($sformatf("mismatch at %0t: stat cycle %0d below minimum %0d",
                         $time, got_cycle, min_cycle));
  endtask

  task automatic check_level(input string name, input logic exp, input logic got);
    if (got !== exp)
      fail_now($sformatf("mismatch at %0t: %s expected %0b, got %0b", $time, name, exp, got));
  endtask

  task automatic send_pkt(input mc_opcode_t op, input mc_addr_t addr, input mc_data_t data);
    kind_e    kind;
    mc_data_t res;
    @(posedge clk_i);
    pkt_v_i    <= 1'b1;
    pkt_op_i   <= op;
    pkt_addr_i <= addr;
    pkt_data_i <= data;
    if (released) begin
      res = ref_model(op, addr, data, kind);
      if (op == MC_OP_STORE && !written[addr]) begin
        written[addr] = 1'b1;
        written_q.push_back(addr);
      end
      if (kind == KIND_RESP) resp_q.push_back('{due: stamp + latency_lp, op: op, data: res});
      if (kind == KIND_STAT) stat_q.push_back('{due: stamp + latency_lp, issue: stamp, tag: data});
      if (kind == KIND_FINISH && finish_due == never_lp) finish_due = stamp + latency_lp;
      last_due = stamp + latency_lp;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      pkt_v_i <= 1'b0;
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!ready_o) begin
      if (n == 64) fail_now("timeout: ready_o never rose after reset release");
      @(posedge clk_i);
      pkt_v_i <= 1'b0;
      n++;
    end
    released = 1'b1;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (stamp <= last_due) begin
      if (n == 16) fail_now("timeout: outstanding packets never reached the outputs");
      @(posedge clk_i);
      pkt_v_i <= 1'b0;
      n++;
    end
  endtask

  initial begin : compare_outputs
    int        t;
    bit        due;
    resp_exp_t re;
    stat_exp_t se;
    mc_cycle_t min_cycle;
    mc_cycle_t prev_cycle;
    int        prev_issue;
    bit        have_prev;
    have_prev  = 1'b0;
    prev_cycle = '0;
    prev_issue = 0;
    @(posedge clk_i);   // outputs settle in the first reset cycle
    forever begin
      @(posedge clk_i);
      t = stamp;
      check_level("ready_o", t >= ready_stamp, ready_o);
      check_level("finish_o", t >= finish_due, finish_o);
      due = resp_q.size() != 0 && resp_q[0].due == t;
      check_level("resp_v_o", due, resp_v_o);
      if (due) begin
        re = resp_q.pop_front();
        check_resp(re.op, re.data, resp_op_o, resp_data_o);
      end
      due = stat_q.size() != 0 && stat_q[0].due == t;
      check_level("stat_v_o", due, stat_v_o);
      if (due) begin
        se        = stat_q.pop_front();
        min_cycle = have_prev ? prev_cycle + mc_cycle_t'(se.issue - prev_issue) : mc_cycle_t'(1);
        check_stat(se.tag, min_cycle, stat_tag_o, stat_cycle_o);
        have_prev  = 1'b1;
        prev_cycle = stat_cycle_o;
        prev_issue = se.issue;
      end
    end
  end

  initial begin : stimulus
    mc_addr_t   a;
    mc_opcode_t op;
    int         sel;
    rst_n_i    = 1'b0;
    pkt_v_i    = 1'b0;
    pkt_op_i   = MC_OP_STORE;
    pkt_addr_i = '0;
    pkt_data_i = '0;
    repeat (5) @(posedge clk_i);
    rst_n_i     <= 1'b1;
    ready_stamp = stamp + init_cycles_lp + reset_depth_lp + 1;

    // dropped during tag programming along with control ops
    repeat (init_cycles_lp) begin
      op = mc_opcode_t'(next_rand());
      a  = (op == MC_OP_CTRL) ? mc_addr_t'(next_rand() & 32'd1) : mc_addr_t'(next_rand());
      send_pkt(op, a, next_rand());
    end
    wait_ready();

    for (int i = 0; i < 8; i++) begin
      a = mc_addr_t'(next_rand());
      send_pkt(MC_OP_STORE, a, next_rand());
      if (i[0]) idle_cycles(1);
      send_pkt(MC_OP_LOAD, a, '0);   // even passes load right behind the store
    end

    a = mc_addr_t'(next_rand());
    send_pkt(MC_OP_STORE, a, next_rand());
    repeat (6) send_pkt(MC_OP_AMOADD, a, next_rand());
    send_pkt(MC_OP_LOAD, a, '0);

    repeat (200) begin
      sel = int'(next_rand() % 32'd3);
      if (sel == 0) send_pkt(MC_OP_STORE, mc_addr_t'(next_rand()), next_rand());
      else if (sel == 1) send_pkt(MC_OP_LOAD, pick_written(), '0);
      else send_pkt(MC_OP_AMOADD, pick_written(), next_rand());
    end

    idle_cycles(2);
    repeat (5) begin
      send_pkt(MC_OP_CTRL, MC_CTRL_PRINT_STAT, next_rand());
      idle_cycles(int'(next_rand() % 32'd4));
    end
    send_pkt(MC_OP_CTRL, mc_addr_t'(32'd2 + next_rand() % 32'd1000), next_rand());
    send_pkt(MC_OP_CTRL, MC_CTRL_PRINT_STAT, next_rand());

    send_pkt(MC_OP_CTRL, MC_CTRL_FINISH, next_rand());
    drain();
    idle_cycles(10);   // finish_o has to hold
    if (resp_q.size() != 0 || stat_q.size() != 0) begin
      fail_now("expected outputs left unchecked at the end of the test");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule
